//--- src/cpuPkg.sv
package cpuPkg;

    // Width of data, addresses and instruction bytes
    localparam int dataWidth = 8;

    // Bus address while no access is made
    localparam logic [dataWidth-1:0] busIdleAddr = 8'hFF;

    //////////////////////////////////////////////////
    // Instruction set

    // Low nibble of the instruction byte
    // Unlisted values act as a no-operation
    typedef enum logic [3:0] {
        readA    = 4'h0,
        readB    = 4'h1,
        writeA   = 4'h2,
        writeB   = 4'h3,
        mathsA   = 4'h4,
        mathsB   = 4'h5,
        branch   = 4'h6,
        gotoAddr = 4'h7,
        goIdle   = 4'h8
    } opcodeT;

    // High nibble for maths and branch instructions
    // Value 15 is left unnamed and yields zero
    typedef enum logic [3:0] {
        add         = 4'h0,
        sub         = 4'h1,
        mul         = 4'h2,
        shiftLeftA  = 4'h3,
        shiftRightA = 4'h4,
        incA        = 4'h5,
        incB        = 4'h6,
        decA        = 4'h7,
        decB        = 4'h8,
        equal       = 4'h9,
        greater     = 4'hA,
        less        = 4'hB,
        andAB       = 4'hC,
        orAB        = 4'hD,
        xorAB       = 4'hE
    } aluOpT;

    //////////////////////////////////////////////////
    // Control to datapath

    // Program counter update for the next cycle
    typedef enum logic [2:0] {
        hold,
        inc1,
        inc2,
        loadRom,
        loadVecA,
        loadVecB
    } pcCmdT;

    typedef struct packed {
        pcCmdT cmd;
        logic  offsetOne;
    } pcCtrlT;

    // Source of a register load
    typedef enum logic [1:0] {
        bus = 2'd0,
        alu = 2'd1
    } regSrcT;

    typedef struct packed {
        logic   loadA;
        logic   loadB;
        regSrcT loadSrc;
        logic   busAddrFromRom;
        logic   writeA;
        logic   writeB;
    } regCtrlT;

    // Core bus output
    typedef struct packed {
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
        logic                 we;
    } busReqT;

endpackage

//--- src/cpuControl.sv
`timescale 1ns/1ns

module cpuControl (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic [cpuPkg::dataWidth-1:0] romData,
    input  logic                         branchTrue,
    input  logic [1:0]                   irqRaise,
    output logic [1:0]                   irqAck,
    output cpuPkg::pcCtrlT               pcCtrl,
    output cpuPkg::regCtrlT              regCtrl,
    output cpuPkg::aluOpT                aluOp
);

    // One chain of states per instruction, all ending back in chooseOp
    typedef enum logic [4:0] {
        idle,
        threadStart0,
        threadStart1,
        threadStart2,
        chooseOp,
        readToA,
        readToB,
        readAddr,
        readWait,
        readCapture,
        writeFromA,
        writeFromB,
        writeIssue,
        mathsToA,
        mathsToB,
        branchStart,
        branchCheck,
        gotoStart,
        gotoLoad,
        gotoIdle,
        settle
    } stateT;

    stateT                        state;
    stateT                        nextState;
    logic [cpuPkg::dataWidth-1:0] instrReg;
    logic                         regSelect;
    logic                         nextRegSelect;
    logic [1:0]                   nextIrqAck;
    cpuPkg::opcodeT               romOpcode;

    // Dispatch works on the byte arriving in chooseOp
    assign romOpcode = cpuPkg::opcodeT'(romData[3:0]);
    assign aluOp     = cpuPkg::aluOpT'(instrReg[7:4]);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= chooseOp;
            regSelect <= 1'b0;
            irqAck    <= 2'b00;
        end else begin
            state     <= nextState;
            regSelect <= nextRegSelect;
            irqAck    <= nextIrqAck;
        end
    end

    // Instruction byte kept for the ALU op field
    always_ff @(posedge CLK) begin
        if (state == chooseOp) begin
            instrReg <= romData;
        end
    end

    always_comb begin
        nextState              = state;
        nextRegSelect          = regSelect;
        nextIrqAck             = 2'b00;
        pcCtrl.cmd             = cpuPkg::hold;
        pcCtrl.offsetOne       = 1'b0;
        regCtrl.loadA          = 1'b0;
        regCtrl.loadB          = 1'b0;
        regCtrl.loadSrc        = cpuPkg::bus;
        regCtrl.busAddrFromRom = 1'b0;
        regCtrl.writeA         = 1'b0;
        regCtrl.writeB         = 1'b0;

        case (state)
            //////////////////////////////////////////////////
            // Sleep and wake-up
            // Line 0 wins when both are raised
            idle: begin
                if (irqRaise[0]) begin
                    nextIrqAck = 2'b01;
                    pcCtrl.cmd = cpuPkg::loadVecA;
                    nextState  = threadStart0;
                end else if (irqRaise[1]) begin
                    nextIrqAck = 2'b10;
                    pcCtrl.cmd = cpuPkg::loadVecB;
                    nextState  = threadStart0;
                end
            end
            // Vector address is on the ROM, wait for its byte
            threadStart0: nextState = threadStart1;
            threadStart1: begin
                pcCtrl.cmd = cpuPkg::loadRom;
                nextState  = threadStart2;
            end
            threadStart2: nextState = chooseOp;

            //////////////////////////////////////////////////
            // Dispatch
            chooseOp: begin
                // Point the ROM at the operand byte
                pcCtrl.offsetOne = 1'b1;
                case (romOpcode)
                    cpuPkg::readA:    nextState = readToA;
                    cpuPkg::readB:    nextState = readToB;
                    cpuPkg::writeA:   nextState = writeFromA;
                    cpuPkg::writeB:   nextState = writeFromB;
                    cpuPkg::mathsA:   nextState = mathsToA;
                    cpuPkg::mathsB:   nextState = mathsToB;
                    cpuPkg::branch:   nextState = branchStart;
                    cpuPkg::gotoAddr: nextState = gotoStart;
                    cpuPkg::goIdle:   nextState = gotoIdle;
                    default: begin
                        // Unknown opcode, step over it
                        pcCtrl.offsetOne = 1'b0;
                        pcCtrl.cmd       = cpuPkg::inc1;
                        nextState        = settle;
                    end
                endcase
            end

            //////////////////////////////////////////////////
            // Memory read, 5 cycles
            readToA, readToB: begin
                nextRegSelect = (state == readToB);
                nextState     = readAddr;
            end
            // Operand byte is here, issue the bus address
            readAddr: begin
                regCtrl.busAddrFromRom = 1'b1;
                nextState              = readWait;
            end
            readWait: begin
                pcCtrl.cmd = cpuPkg::inc2;
                nextState  = readCapture;
            end
            readCapture: begin
                regCtrl.loadA = !regSelect;
                regCtrl.loadB = regSelect;
                nextState     = chooseOp;
            end

            //////////////////////////////////////////////////
            // Memory write, 3 cycles
            writeFromA, writeFromB: begin
                nextRegSelect = (state == writeFromB);
                pcCtrl.cmd    = cpuPkg::inc2;
                nextState     = writeIssue;
            end
            writeIssue: begin
                regCtrl.writeA = !regSelect;
                regCtrl.writeB = regSelect;
                nextState      = chooseOp;
            end

            //////////////////////////////////////////////////
            // Maths, branch and jumps
            mathsToA, mathsToB: begin
                regCtrl.loadA   = (state == mathsToA);
                regCtrl.loadB   = (state == mathsToB);
                regCtrl.loadSrc = cpuPkg::alu;
                pcCtrl.cmd      = cpuPkg::inc1;
                nextState       = settle;
            end
            // Step past the operand now so a miss needs no extra cycle
            branchStart: begin
                pcCtrl.cmd = cpuPkg::inc2;
                nextState  = branchCheck;
            end
            branchCheck: begin
                if (branchTrue) begin
                    pcCtrl.cmd = cpuPkg::loadRom;
                    nextState  = settle;
                end else begin
                    nextState = chooseOp;
                end
            end
            gotoStart: nextState = gotoLoad;
            gotoLoad: begin
                pcCtrl.cmd = cpuPkg::loadRom;
                nextState  = settle;
            end
            gotoIdle: nextState = idle;
            // New PC reaches the ROM, its byte arrives next cycle
            settle: nextState = chooseOp;
            default: nextState = chooseOp;
        endcase
    end

    // Only one line is acknowledged at a time
    irqAckOneHot: assert property (@(posedge CLK) disable iff (RESET) $onehot0(irqAck));

endmodule

//--- src/progCounter.sv
`timescale 1ns/1ns

module progCounter #(
    parameter logic [cpuPkg::dataWidth-1:0] irqVectorA = 8'hFF,
    parameter logic [cpuPkg::dataWidth-1:0] irqVectorB = 8'hFE
) (
    input  logic                         CLK,
    input  logic                         RESET,
    input  cpuPkg::pcCtrlT               pcCtrl,
    input  logic [cpuPkg::dataWidth-1:0] romData,
    output logic [cpuPkg::dataWidth-1:0] romAddr
);

    localparam logic [cpuPkg::dataWidth-1:0] stepOne = 1;
    localparam logic [cpuPkg::dataWidth-1:0] stepTwo = 2;

    logic [cpuPkg::dataWidth-1:0] pc;
    logic                         offsetOne;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc        <= '0;
            offsetOne <= 1'b0;
        end else begin
            offsetOne <= pcCtrl.offsetOne;
            case (pcCtrl.cmd)
                cpuPkg::inc1:     pc <= pc + stepOne;
                cpuPkg::inc2:     pc <= pc + stepTwo;
                cpuPkg::loadRom:  pc <= romData;
                // Vectors point at ROM bytes holding the thread start
                cpuPkg::loadVecA: pc <= irqVectorA;
                cpuPkg::loadVecB: pc <= irqVectorB;
                default:          pc <= pc;
            endcase
        end
    end

    // Offset selects the operand byte after the opcode
    assign romAddr = pc + {{(cpuPkg::dataWidth-1){1'b0}}, offsetOne};

    // Operand fetch lasts a single cycle
    offsetSingle: assert property (@(posedge CLK) disable iff (RESET) offsetOne |=> !offsetOne);

endmodule

//--- src/regBank.sv
`timescale 1ns/1ns

module regBank (
    input  logic                         CLK,
    input  logic                         RESET,
    input  cpuPkg::regCtrlT              regCtrl,
    input  logic [cpuPkg::dataWidth-1:0] romData,
    input  logic [cpuPkg::dataWidth-1:0] busRdata,
    input  logic [cpuPkg::dataWidth-1:0] aluResult,
    output logic [cpuPkg::dataWidth-1:0] regA,
    output logic [cpuPkg::dataWidth-1:0] regB,
    output cpuPkg::busReqT               busOut
);

    logic [cpuPkg::dataWidth-1:0] loadValue;
    logic [cpuPkg::dataWidth-1:0] busAddr;
    logic [cpuPkg::dataWidth-1:0] busWdata;
    logic                         busWe;
    logic                         writeCmd;

    assign loadValue = (regCtrl.loadSrc == cpuPkg::alu) ? aluResult : busRdata;
    assign writeCmd  = regCtrl.writeA | regCtrl.writeB;

    //////////////////////////////////////////////////
    // Working registers
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
        end else begin
            if (regCtrl.loadA) begin
                regA <= loadValue;
            end
            if (regCtrl.loadB) begin
                regB <= loadValue;
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus request
    // Address falls back to idle after every access
    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= cpuPkg::busIdleAddr;
            busWe   <= 1'b0;
        end else begin
            busAddr <= (regCtrl.busAddrFromRom || writeCmd) ? romData : cpuPkg::busIdleAddr;
            busWe   <= writeCmd;
        end
    end

    // Write data only changes on a write
    always_ff @(posedge CLK) begin
        if (writeCmd) begin
            busWdata <= regCtrl.writeB ? regB : regA;
        end
    end

    assign busOut = '{addr: busAddr, wdata: busWdata, we: busWe};

    // Control never targets both registers
    singleLoad: assert property (@(posedge CLK) disable iff (RESET)
        !(regCtrl.loadA && regCtrl.loadB));

endmodule

//--- src/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [cpuPkg::dataWidth-1:0] regA,
    input  logic [cpuPkg::dataWidth-1:0] regB,
    input  cpuPkg::aluOpT                aluOp,
    output logic [cpuPkg::dataWidth-1:0] aluResult,
    output logic                         branchTrue
);

    localparam logic [cpuPkg::dataWidth-1:0] stepOne = 1;

    // Zero extension for compare flags
    localparam logic [cpuPkg::dataWidth-2:0] flagPad = '0;

    always_comb begin
        case (aluOp)
            cpuPkg::add:         aluResult = regA + regB;
            cpuPkg::sub:         aluResult = regA - regB;
            // Low byte of the product
            cpuPkg::mul:         aluResult = regA * regB;
            cpuPkg::shiftLeftA:  aluResult = regA << 1;
            cpuPkg::shiftRightA: aluResult = regA >> 1;
            cpuPkg::incA:        aluResult = regA + stepOne;
            cpuPkg::incB:        aluResult = regB + stepOne;
            cpuPkg::decA:        aluResult = regA - stepOne;
            cpuPkg::decB:        aluResult = regB - stepOne;
            // Compares give one or zero, unsigned
            cpuPkg::equal:       aluResult = {flagPad, regA == regB};
            cpuPkg::greater:     aluResult = {flagPad, regA > regB};
            cpuPkg::less:        aluResult = {flagPad, regA < regB};
            cpuPkg::andAB:       aluResult = regA & regB;
            cpuPkg::orAB:        aluResult = regA | regB;
            cpuPkg::xorAB:       aluResult = regA ^ regB;
            default:             aluResult = '0;
        endcase
    end

    // Branch condition from the compare flag
    assign branchTrue = aluResult[0];

endmodule

//--- src/microCpu.sv
`timescale 1ns/1ns

module microCpu #(
    parameter logic [cpuPkg::dataWidth-1:0] irqVectorA = 8'hFF,
    parameter logic [cpuPkg::dataWidth-1:0] irqVectorB = 8'hFE
) (
    input  logic                         CLK,
    input  logic                         RESET,
    output cpuPkg::busReqT               busOut,
    input  logic [cpuPkg::dataWidth-1:0] busRdata,
    output logic [cpuPkg::dataWidth-1:0] romAddr,
    input  logic [cpuPkg::dataWidth-1:0] romData,
    input  logic [1:0]                   irqRaise,
    output logic [1:0]                   irqAck
);

    cpuPkg::pcCtrlT               pcCtrl;
    cpuPkg::regCtrlT              regCtrl;
    cpuPkg::aluOpT                aluOp;
    logic [cpuPkg::dataWidth-1:0] regA;
    logic [cpuPkg::dataWidth-1:0] regB;
    logic [cpuPkg::dataWidth-1:0] aluResult;
    logic                         branchTrue;

    // Instruction sequencing and interrupts
    cpuControl uControl (
        .CLK        (CLK),
        .RESET      (RESET),
        .romData    (romData),
        .branchTrue (branchTrue),
        .irqRaise   (irqRaise),
        .irqAck     (irqAck),
        .pcCtrl     (pcCtrl),
        .regCtrl    (regCtrl),
        .aluOp      (aluOp)
    );

    // ROM address generation
    progCounter #(
        .irqVectorA (irqVectorA),
        .irqVectorB (irqVectorB)
    ) uPc (
        .CLK     (CLK),
        .RESET   (RESET),
        .pcCtrl  (pcCtrl),
        .romData (romData),
        .romAddr (romAddr)
    );

    // Registers and data bus
    regBank uRegs (
        .CLK       (CLK),
        .RESET     (RESET),
        .regCtrl   (regCtrl),
        .romData   (romData),
        .busRdata  (busRdata),
        .aluResult (aluResult),
        .regA      (regA),
        .regB      (regB),
        .busOut    (busOut)
    );

    alu uAlu (
        .regA       (regA),
        .regB       (regB),
        .aluOp      (aluOp),
        .aluResult  (aluResult),
        .branchTrue (branchTrue)
    );

endmodule

//--- dv/memModel.sv
`timescale 1ns/1ns

module memModel (
    input  logic                         CLK,
    input  logic                         clearLog,
    input  logic [cpuPkg::dataWidth-1:0] romAddr,
    output logic [cpuPkg::dataWidth-1:0] romData,
    input  cpuPkg::busReqT               busOut,
    output logic [cpuPkg::dataWidth-1:0] busRdata
);

    // Program and data storage loaded by the testbench
    logic [7:0] rom [0:255];
    logic [7:0] ram [0:255];

    // Write log in arrival order
    logic [7:0] logAddr [0:63];
    logic [7:0] logData [0:63];
    int         logCount;
    logic       weLast;
    logic       weTooLong;

    always @(posedge CLK) begin
        // One-cycle read latency on both memories
        romData  <= rom[romAddr];
        busRdata <= ram[busOut.addr];
        if (clearLog) begin
            logCount  <= 0;
            weLast    <= 1'b0;
            weTooLong <= 1'b0;
        end else begin
            weLast <= busOut.we;
            if (busOut.we) begin
                // Read data above was sampled before this update
                ram[busOut.addr] = busOut.wdata;
                if (logCount < 64) begin
                    logAddr[logCount] <= busOut.addr;
                    logData[logCount] <= busOut.wdata;
                end
                logCount <= logCount + 1;
                // A write strobe must not last two cycles
                if (weLast) begin
                    weTooLong <= 1'b1;
                end
            end
        end
    end

endmodule

//--- dv/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;

    localparam int timeoutLimit = 5000;

    logic                         CLK;
    logic                         RESET;
    logic                         clearLog;
    cpuPkg::busReqT               busOut;
    logic [cpuPkg::dataWidth-1:0] busRdata;
    logic [cpuPkg::dataWidth-1:0] romAddr;
    logic [cpuPkg::dataWidth-1:0] romData;
    logic [1:0]                   irqRaise;
    logic [1:0]                   irqAck;

    int          cycles = 0;
    int          progPtr;
    int unsigned seedValue;

    // Expected write log
    logic [7:0] expAddr [0:63];
    logic [7:0] expData [0:63];
    int         expCount;

    microCpu #(
        .irqVectorA (8'hFF),
        .irqVectorB (8'hFE)
    ) u_dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .busOut   (busOut),
        .busRdata (busRdata),
        .romAddr  (romAddr),
        .romData  (romData),
        .irqRaise (irqRaise),
        .irqAck   (irqAck)
    );

    memModel mem (
        .CLK      (CLK),
        .clearLog (clearLog),
        .romAddr  (romAddr),
        .romData  (romData),
        .busOut   (busOut),
        .busRdata (busRdata)
    );

    initial begin
        CLK = 1'b0;
    end

    always #10 CLK = ~CLK;

    // Run limit well above the length of all tests
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeoutLimit);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////
    // Checking

    task automatic checkEq(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // Reference results from the instruction set rules
    function automatic logic [7:0] expectAlu(input logic [3:0] op, input logic [7:0] a,
                                             input logic [7:0] b);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a * b;
            4'd3:    return {a[6:0], 1'b0};
            4'd4:    return {1'b0, a[7:1]};
            4'd5:    return a + 8'd1;
            4'd6:    return b + 8'd1;
            4'd7:    return a - 8'd1;
            4'd8:    return b - 8'd1;
            4'd9:    return (a == b) ? 8'd1 : 8'd0;
            4'd10:   return (a > b) ? 8'd1 : 8'd0;
            4'd11:   return (a < b) ? 8'd1 : 8'd0;
            4'd12:   return a & b;
            4'd13:   return a | b;
            4'd14:   return a ^ b;
            default: return 8'd0;
        endcase
    endfunction

    task automatic expectWrite(input logic [7:0] addr, input logic [7:0] data);
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expCount++;
    endtask

    // Wait for the logged writes and compare them in order
    task automatic runAndCompare();
        while (mem.logCount < expCount) begin
            @(negedge CLK);
        end
        for (int k = 0; k < expCount; k++) begin
            checkEq($sformatf("write %0d busOut.addr", k), mem.logAddr[k], expAddr[k]);
            checkEq($sformatf("write %0d busOut.wdata", k), mem.logData[k], expData[k]);
        end
        checkEq("busOut.we high two cycles", {7'b0, mem.weTooLong}, 8'h00);
    endtask

    //////////////////////////////////////////////////
    // Program building

    task automatic emit(input logic [7:0] b);
        mem.rom[progPtr[7:0]] = b;
        progPtr++;
    endtask

    task automatic emitRead(input logic toB, input logic [7:0] addr);
        emit(toB ? 8'h01 : 8'h00);
        emit(addr);
    endtask

    task automatic emitWrite(input logic fromB, input logic [7:0] addr);
        emit(fromB ? 8'h03 : 8'h02);
        emit(addr);
    endtask

    task automatic emitBranch(input logic [3:0] op, input logic [7:0] target);
        emit({op, 4'h6});
        emit(target);
    endtask

    task automatic emitGoto(input logic [7:0] target);
        emit(8'h07);
        emit(target);
    endtask

    // Hold reset while memories are refilled
    task automatic startProgram();
        @(negedge CLK);
        RESET    = 1'b1;
        clearLog = 1'b1;
        irqRaise = 2'b00;
        for (int i = 0; i < 256; i++) begin
            mem.rom[i] = 8'(i) ^ 8'h3C;
            mem.ram[i] = 8'(i * 7) ^ 8'hA5;
        end
        progPtr  = 0;
        expCount = 0;
    endtask

    task automatic releaseReset();
        repeat (3) @(negedge CLK);
        RESET    = 1'b0;
        clearLog = 1'b0;
        // Outputs still at reset values before the first instruction
        checkEq("busOut.we", {7'b0, busOut.we}, 8'h00);
        checkEq("irqAck", {6'b0, irqAck}, 8'h00);
        checkEq("busOut.addr", busOut.addr, 8'hFF);
        checkEq("romAddr", romAddr, 8'h00);
    endtask

    //////////////////////////////////////////////////
    // Tests

    task automatic readWriteTest();
        logic [7:0] v1;
        logic [7:0] v2;
        startProgram();
        v1 = 8'($urandom);
        v2 = 8'($urandom);
        mem.ram[8'h10] = v1;
        mem.ram[8'h11] = v2;
        emitRead(1'b0, 8'h10);
        emitRead(1'b1, 8'h11);
        emitWrite(1'b0, 8'h20);
        emitWrite(1'b1, 8'h21);
        emit(8'h08);
        expectWrite(8'h20, v1);
        expectWrite(8'h21, v2);
        releaseReset();
        runAndCompare();
    endtask

    // One block per ALU op with the destination alternating between A and B
    task automatic aluTest();
        logic [7:0] a;
        logic [7:0] b;
        logic [3:0] op;
        logic       toB;
        startProgram();
        for (int k = 0; k < 16; k++) begin
            op  = 4'(k);
            toB = op[0];
            a   = 8'($urandom);
            b   = 8'($urandom);
            mem.ram[8'(8'h30 + 2 * k)] = a;
            mem.ram[8'(8'h31 + 2 * k)] = b;
            emitRead(1'b0, 8'(8'h30 + 2 * k));
            emitRead(1'b1, 8'(8'h31 + 2 * k));
            emit({op, toB ? 4'h5 : 4'h4});
            emitWrite(toB, 8'(8'h80 + k));
            expectWrite(8'(8'h80 + k), expectAlu(op, a, b));
        end
        emit(8'h08);
        releaseReset();
        runAndCompare();
    endtask

    // Each compare taken and not taken and then a goto over a write
    task automatic branchTest();
        logic [7:0] lo;
        logic [7:0] hi;
        logic [7:0] a;
        logic [7:0] b;
        logic       taken;
        int         cond;
        startProgram();
        lo = 8'($urandom % 128);
        hi = lo + 8'd1 + 8'($urandom % 127);
        for (int k = 0; k < 6; k++) begin
            cond = k / 2;
            // Equal operands only in the first case
            a = lo;
            b = hi;
            if (k == 0) begin
                b = lo;
            end else if (k == 2 || k == 5) begin
                a = hi;
                b = lo;
            end
            taken = (cond == 0) ? (a == b) : (cond == 1) ? (a > b) : (a < b);
            mem.ram[8'(8'h30 + 2 * k)] = a;
            mem.ram[8'(8'h31 + 2 * k)] = b;
            emitRead(1'b0, 8'(8'h30 + 2 * k));
            emitRead(1'b1, 8'(8'h31 + 2 * k));
            emitBranch(4'(9 + cond), 8'(progPtr + 6));
            // Fall-through path jumps over the taken path
            emitWrite(1'b0, 8'(8'h60 + k));
            emitGoto(8'(progPtr + 4));
            emitWrite(1'b0, 8'(8'h70 + k));
            expectWrite(taken ? 8'(8'h70 + k) : 8'(8'h60 + k), a);
        end
        emitGoto(8'(progPtr + 4));
        emitWrite(1'b0, 8'h7E);
        emitWrite(1'b0, 8'h7F);
        expectWrite(8'h7F, hi);
        emit(8'h08);
        releaseReset();
        runAndCompare();
    endtask

    task automatic raiseIrq(input logic [1:0] lines, input logic [1:0] expAck);
        @(negedge CLK);
        irqRaise = lines;
        while (irqAck == 2'b00) begin
            @(negedge CLK);
        end
        checkEq("irqAck", {6'b0, irqAck}, {6'b0, expAck});
        irqRaise = 2'b00;
        @(negedge CLK);
        checkEq("irqAck after pulse", {6'b0, irqAck}, 8'h00);
    endtask

    task automatic irqTest();
        logic [7:0] m1;
        logic [7:0] m2;
        startProgram();
        m1 = 8'($urandom);
        m2 = 8'($urandom);
        mem.ram[8'h12] = m1;
        mem.ram[8'h13] = m2;
        emit(8'h08);
        // Line 1 thread
        progPtr = 'h40;
        emitRead(1'b0, 8'h12);
        emitWrite(1'b0, 8'hE1);
        emit(8'h08);
        // Line 0 thread
        progPtr = 'h50;
        emitRead(1'b0, 8'h13);
        emitWrite(1'b0, 8'hE0);
        emit(8'h08);
        mem.rom[8'hFE] = 8'h40;
        mem.rom[8'hFF] = 8'h50;
        releaseReset();
        raiseIrq(2'b10, 2'b10);
        expectWrite(8'hE1, m1);
        runAndCompare();
        raiseIrq(2'b11, 2'b01);
        expectWrite(8'hE0, m2);
        runAndCompare();
    endtask

    initial begin
        RESET     = 1'b1;
        clearLog  = 1'b1;
        irqRaise  = 2'b00;
        expCount  = 0;
        progPtr   = 0;
        seedValue = $urandom(54);
        readWriteTest();
        aluTest();
        branchTest();
        irqTest();
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- flist.f
src/cpuPkg.sv
src/cpuControl.sv
src/progCounter.sv
src/regBank.sv
src/alu.sv
src/microCpu.sv
dv/memModel.sv
dv/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f flist.f -o simv

output=$(./obj_dir/simv) || true
echo "$output"

if grep -q "TB PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
